// ==== design/ht_defines.svh ====
`ifndef HT_DEFINES_SVH
`define HT_DEFINES_SVH

// ==================================================
// Virtual address split
// ==================================================

// Low address bits pass through translation untouched
`define HT_OFS_BITS  18
`define HT_VPN_BITS  14
`define HT_PPN_BITS  14

// ==================================================
// Page table geometry
// ==================================================

`define HT_GROUPS    16
`define HT_GRP_BITS  4
`define HT_SLOTS     8
`define HT_SLOT_BITS 3

// Register word addresses as seen on adr bits 3 to 2
`define HT_REG_VADR  2'd0
`define HT_REG_ENTRY 2'd1
`define HT_REG_CTRL  2'd2
`define HT_REG_STAT  2'd3

`endif

// ==== design/hash_table_pkg.sv ====
`include "ht_defines.svh"

package hash_table_pkg;

	// ==================================================
	// Table storage
	// ==================================================

	// A single translation from virtual page to physical page
	typedef struct packed {
		logic                    valid;
		logic [`HT_VPN_BITS-1:0] vpn;
		logic [`HT_PPN_BITS-1:0] ppn;
	} ptge_t;

	// Eight entries share one hash bucket and are searched together
	typedef struct packed {
		ptge_t [`HT_SLOTS-1:0] ptge;
	} ptg_t;

	// ==================================================
	// Links between the bus port and the engine
	// ==================================================

	typedef struct packed {
		logic [31:0] vadr;
		logic        xlat;
	} ht_req_t;

	// The group is not carried since the memory hashes the vpn itself
	typedef struct packed {
		logic [`HT_SLOT_BITS-1:0] slot;
		ptge_t                    ent;
	} ht_wr_t;

	typedef struct packed {
		logic                     found;
		logic [`HT_SLOT_BITS-1:0] which;
	} ht_res_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_CMP,
		ST_DONE
	} ht_state_e;

	typedef enum logic [2:0] {
		OP_NONE,
		OP_LOOKUP,
		OP_LOAD,
		OP_CTRL,
		OP_RD_PADR,
		OP_RD_STAT
	} wb_op_e;

	// With translation off every address is considered valid
	localparam logic VAL = 1'b1;

	// Folds the twelve low page number bits into a group index
	function automatic logic [`HT_GRP_BITS-1:0] ht_hash(input logic [`HT_VPN_BITS-1:0] vpn);
		return vpn[3:0] ^ vpn[7:4] ^ vpn[11:8];
	endfunction

endpackage

// ==== design/ht_wb_port.sv ====
`include "ht_defines.svh"

module ht_wb_port import hash_table_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [3:0]  wb_adr,
	input  logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic        wb_ack,
	output ht_wr_t      wr,
	output logic        wr_en,
	output ht_req_t     req,
	output logic        req_valid,
	input  ht_res_t     res,
	input  logic        done,
	input  logic [31:0] padr,
	input  logic        padrv
);

	logic        xlat_en;
	logic        lookup_busy;
	logic        start;
	wb_op_e      op;
	logic [31:0] padr_q;
	logic        padrv_q;
	logic        found_q;

	// ==================================================
	// Request decode
	// ==================================================

	// A cycle is new only when no ack is out and no lookup is pending
	// The master keeps stb up during the ack cycle so that must be masked
	assign start = wb_cyc && wb_stb && !wb_ack && !lookup_busy;

	always_comb begin
		op = OP_NONE;
		if (start) begin
			if (wb_we) begin
				case (wb_adr[3:2])
					`HT_REG_VADR:  op = OP_LOOKUP;
					`HT_REG_ENTRY: op = OP_LOAD;
					`HT_REG_CTRL:  op = OP_CTRL;
					default:       op = OP_NONE;
				endcase
			end else begin
				case (wb_adr[3:2])
					`HT_REG_VADR: op = OP_RD_PADR;
					`HT_REG_STAT: op = OP_RD_STAT;
					default:      op = OP_NONE;
				endcase
			end
		end
	end

	// ==================================================
	// Control state
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack      <= 1'b0;
			req_valid   <= 1'b0;
			wr_en       <= 1'b0;
			xlat_en     <= 1'b0;
			lookup_busy <= 1'b0;
			padr_q      <= '0;
			padrv_q     <= 1'b0;
			found_q     <= 1'b0;
		end else begin
			// Both launch strobes last exactly one cycle
			req_valid <= (op == OP_LOOKUP);
			wr_en     <= (op == OP_LOAD);
			// Everything but a lookup acks in the next cycle
			// Unmapped registers are acked too so the bus never hangs
			wb_ack <= (start && op != OP_LOOKUP) || done;
			if (op == OP_CTRL)
				xlat_en <= wb_dat_w[0];
			if (op == OP_LOOKUP)
				lookup_busy <= 1'b1;
			else if (done)
				lookup_busy <= 1'b0;
			// Results are captured once per lookup and read back later
			if (done) begin
				padr_q  <= padr;
				padrv_q <= padrv;
				found_q <= res.found;
			end
		end
	end

	// ==================================================
	// Payload registers
	// ==================================================

	always_ff @(posedge clk) begin
		// The enable is sampled with the address so a lookup sees one mode
		if (op == OP_LOOKUP) begin
			req.vadr <= wb_dat_w;
			req.xlat <= xlat_en;
		end
		// Entry word layout is valid, slot, ppn, vpn from the top down
		if (op == OP_LOAD) begin
			wr.ent.valid <= wb_dat_w[31];
			wr.slot      <= wb_dat_w[30:28];
			wr.ent.ppn   <= wb_dat_w[27:14];
			wr.ent.vpn   <= wb_dat_w[13:0];
		end
		if (start && !wb_we) begin
			case (op)
				OP_RD_PADR: wb_dat_r <= padr_q;
				OP_RD_STAT: wb_dat_r <= {30'd0, found_q, padrv_q};
				default:    wb_dat_r <= '0;
			endcase
		end
	end

endmodule

// ==== design/ht_ptg_ram.sv ====
`include "ht_defines.svh"

module ht_ptg_ram import hash_table_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  ht_wr_t                  wr,
	input  logic                    wr_en,
	input  logic                    rd_en,
	input  logic [`HT_GRP_BITS-1:0] rd_grp,
	output ptg_t                    rec,
	output logic                    busy
);

	ptg_t                    mem [`HT_GROUPS];
	logic [`HT_GRP_BITS-1:0] sweep;
	logic [`HT_GRP_BITS-1:0] wr_grp;

	// The entry lands in the group its own page number hashes to
	assign wr_grp = ht_hash(wr.ent.vpn);

	// ==================================================
	// Clearing sweep after reset
	// ==================================================

	// One row per cycle so the whole table is clean after 16 cycles
	always_ff @(posedge clk) begin
		if (rst) begin
			sweep <= '0;
			busy  <= 1'b1;
		end else if (busy) begin
			sweep <= sweep + 1'b1;
			if (sweep == `HT_GRP_BITS'(`HT_GROUPS - 1))
				busy <= 1'b0;
		end
	end

	// ==================================================
	// Storage
	// ==================================================

	always_ff @(posedge clk) begin
		if (busy)
			mem[sweep] <= '0;
		else if (wr_en)
			mem[wr_grp].ptge[wr.slot] <= wr.ent;
		// Output holds between reads so the former sees a steady group
		if (rd_en)
			rec <= mem[rd_grp];
	end

endmodule

// ==== design/ht_search.sv ====
`include "ht_defines.svh"

module ht_search import hash_table_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  ht_req_t                 req,
	input  logic                    req_valid,
	input  logic                    busy,
	output logic                    rd_en,
	output logic [`HT_GRP_BITS-1:0] rd_grp,
	input  ptg_t                    rec,
	output ht_res_t                 res,
	output logic                    done
);

	ht_state_e                state;
	logic                     pend;
	logic [`HT_VPN_BITS-1:0]  vpn;
	logic [`HT_SLOTS-1:0]     hit;
	logic                     any_hit;
	logic [`HT_SLOT_BITS-1:0] first;

	// The port holds the request steady until the ack
	assign vpn    = req.vadr[31:`HT_OFS_BITS];
	assign rd_grp = ht_hash(vpn);
	assign rd_en  = (state == ST_READ);
	assign done   = (state == ST_DONE);

	// ==================================================
	// Tag compare
	// ==================================================

	// All eight slots are checked at once against the request
	always_comb begin
		hit = '0;
		for (int i = 0; i < `HT_SLOTS; i++)
			hit[i] = rec.ptge[i].valid && (rec.ptge[i].vpn == vpn);
	end

	assign any_hit = |hit;

	// Scanning downward leaves the lowest matching slot
	always_comb begin
		first = '0;
		for (int i = `HT_SLOTS - 1; i >= 0; i--) begin
			if (hit[i])
				first = `HT_SLOT_BITS'(i);
		end
	end

	// ==================================================
	// Search FSM
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			pend  <= 1'b0;
			res   <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					// A request during the clearing sweep is remembered
					if ((req_valid || pend) && !busy) begin
						state <= ST_READ;
						pend  <= 1'b0;
					end else if (req_valid) begin
						pend <= 1'b1;
					end
				end
				// Memory returns the group at the end of this cycle
				ST_READ: state <= ST_CMP;
				ST_CMP: begin
					res.found <= any_hit;
					res.which <= first;
					state     <= ST_DONE;
				end
				ST_DONE: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== design/ht_padr.sv ====
`include "ht_defines.svh"

module ht_padr import hash_table_pkg::*; (
	input  logic                     rst,
	input  logic                     clk,
	input  logic                     xlat,
	input  logic                     found,
	input  logic [`HT_SLOT_BITS-1:0] which,
	input  ptg_t                     rec,
	input  logic [31:0]              vadr,
	output logic [31:0]              padr,
	output logic                     padrv
);

	// ==================================================
	// Physical address former
	// ==================================================

	// Pure combinational path from the held group and the search result
	always_comb begin
		// Page offset is never translated
		padr[`HT_OFS_BITS-1:0] = vadr[`HT_OFS_BITS-1:0];
		if (xlat) begin
			// Swap in the page number of the matching slot
			padr[31:`HT_OFS_BITS] = rec.ptge[which].ppn;
			padrv = found;
		end else begin
			padr[31:`HT_OFS_BITS] = vadr[31:`HT_OFS_BITS];
			padrv = VAL;
		end
	end

endmodule

// ==== design/ht_xlat_top.sv ====
`include "ht_defines.svh"

module ht_xlat_top import hash_table_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [3:0]  wb_adr,
	input  logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic        wb_ack
);

	ht_wr_t                  wr;
	logic                    wr_en;
	ht_req_t                 req;
	logic                    req_valid;
	ht_res_t                 res;
	logic                    done;
	logic [31:0]             padr;
	logic                    padrv;
	logic                    rd_en;
	logic [`HT_GRP_BITS-1:0] rd_grp;
	ptg_t                    rec;
	logic                    busy;

	// ==================================================
	// Bus side
	// ==================================================

	ht_wb_port u_port (
		.clk       (clk),
		.rst       (rst),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.wr        (wr),
		.wr_en     (wr_en),
		.req       (req),
		.req_valid (req_valid),
		.res       (res),
		.done      (done),
		.padr      (padr),
		.padrv     (padrv)
	);

	// ==================================================
	// Table and lookup path
	// ==================================================

	ht_ptg_ram u_ram (
		.clk    (clk),
		.rst    (rst),
		.wr     (wr),
		.wr_en  (wr_en),
		.rd_en  (rd_en),
		.rd_grp (rd_grp),
		.rec    (rec),
		.busy   (busy)
	);

	ht_search u_search (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.req_valid (req_valid),
		.busy      (busy),
		.rd_en     (rd_en),
		.rd_grp    (rd_grp),
		.rec       (rec),
		.res       (res),
		.done      (done)
	);

	// Group output stays valid through ST_DONE when the port samples
	ht_padr u_padr (
		.rst   (rst),
		.clk   (clk),
		.xlat  (req.xlat),
		.found (res.found),
		.which (res.which),
		.rec   (rec),
		.vadr  (req.vadr),
		.padr  (padr),
		.padrv (padrv)
	);

endmodule

// ==== sim/ht_xlat_chk.sv ====
module ht_xlat_chk import hash_table_pkg::*; (
	input logic      clk,
	input logic      rst,
	input logic      wb_cyc,
	input logic      wb_stb,
	input logic      wb_ack,
	input logic      done,
	input logic      busy,
	input ht_state_e state
);

	timeunit 1ns;
	timeprecision 1ps;

	// ==================================================
	// Wishbone classic handshake
	// ==================================================

	// The slave may only answer a cycle that the master is running
	ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
		wb_ack |-> (wb_cyc && wb_stb))
		else $error("Ack was raised outside of a bus cycle");

	// Every ack is a single cycle pulse
	ack_single: assert property (@(posedge clk) disable iff (rst)
		wb_ack |=> !wb_ack)
		else $error("Ack stayed high for two cycles");

	// ==================================================
	// Search engine
	// ==================================================

	// The port turns the end of a search into the lookup ack
	done_acked: assert property (@(posedge clk) disable iff (rst)
		done |=> wb_ack)
		else $error("Search finished without an ack in the next cycle");

	// Nothing is read from the table while the clearing sweep runs
	idle_while_busy: assert property (@(posedge clk) disable iff (rst)
		(busy && state == ST_IDLE) |=> (state == ST_IDLE))
		else $error("Search left idle during the table sweep");

endmodule

bind ht_xlat_top ht_xlat_chk u_chk (
	.clk    (clk),
	.rst    (rst),
	.wb_cyc (wb_cyc),
	.wb_stb (wb_stb),
	.wb_ack (wb_ack),
	.done   (done),
	.busy   (busy),
	.state  (u_search.state)
);

// ==== sim/ht_xlat_tb.sv ====
`include "ht_defines.svh"

module ht_xlat_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// The worst case run is about 550 transactions
	// A lookup write takes about six cycles so ten per transaction leaves margin
	localparam int XACT_BUDGET = 600;
	localparam int WATCHDOG_NS = (22 + XACT_BUDGET * 10) * 10;

	localparam logic [3:0] ADR_VADR  = {`HT_REG_VADR, 2'b00};
	localparam logic [3:0] ADR_ENTRY = {`HT_REG_ENTRY, 2'b00};
	localparam logic [3:0] ADR_CTRL  = {`HT_REG_CTRL, 2'b00};
	localparam logic [3:0] ADR_STAT  = {`HT_REG_STAT, 2'b00};

	typedef struct packed {
		logic                    valid;
		logic [`HT_VPN_BITS-1:0] vpn;
		logic [`HT_PPN_BITS-1:0] ppn;
	} ent_t;

	typedef struct packed {
		logic [31:0] padr;
		logic        padrv;
		logic        found;
	} xres_t;

	logic                    clk = 1'b0;
	logic                    rst;
	logic                    wb_cyc;
	logic                    wb_stb;
	logic                    wb_we;
	logic [3:0]              wb_adr;
	logic [31:0]             wb_dat_w;
	logic [31:0]             wb_dat_r;
	logic                    wb_ack;
	logic                    xlat_on;
	int                      seed = 68117;
	ent_t                    shadow [`HT_GROUPS][`HT_SLOTS];
	logic [`HT_VPN_BITS-1:0] pool [12];
	string                   name_q [$];
	xres_t                   exp_q [$];
	xres_t                   act_q [$];

	ht_xlat_top u_ht_xlat_top (
		.clk      (clk),
		.rst      (rst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	always #5 clk = ~clk;

	// ==================================================
	// Reference model
	// ==================================================

	// Group index folds the three low nibbles of the page number
	function automatic logic [3:0] bucket(input logic [`HT_VPN_BITS-1:0] vpn);
		return vpn[3:0] ^ vpn[7:4] ^ vpn[11:8];
	endfunction

	function automatic xres_t ref_xlat(input logic [31:0] vadr, input logic xlat);
		xres_t                   r;
		logic [3:0]              g;
		logic [`HT_VPN_BITS-1:0] vpn;
		vpn     = vadr[31:`HT_OFS_BITS];
		g       = bucket(vpn);
		r.found = 1'b0;
		r.padr  = vadr;
		// Walking down from the top leaves the lowest matching slot
		for (int s = `HT_SLOTS - 1; s >= 0; s--) begin
			if (shadow[g][s].valid && shadow[g][s].vpn == vpn) begin
				r.found = 1'b1;
				r.padr  = {shadow[g][s].ppn, vadr[`HT_OFS_BITS-1:0]};
			end
		end
		if (!xlat)
			r.padr = vadr;
		r.padrv = xlat ? r.found : 1'b1;
		return r;
	endfunction

	// ==================================================
	// Bus tasks
	// ==================================================

	// Signals are held through the cycle in which the ack is sampled
	task automatic bus_cycle(input logic we, input logic [3:0] adr,
			input logic [31:0] dat_w, output logic [31:0] dat_r);
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat_w;
		@(negedge clk);
		while (!wb_ack)
			@(negedge clk);
		dat_r = wb_dat_r;
		@(negedge clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
		bus_cycle(1'b0, adr, 32'd0, dat);
	endtask

	task automatic load_entry(input logic [2:0] slot, input logic valid,
			input logic [`HT_VPN_BITS-1:0] vpn, input logic [`HT_PPN_BITS-1:0] ppn);
		wb_write(ADR_ENTRY, {valid, slot, ppn, vpn});
		shadow[bucket(vpn)][slot] = '{valid: valid, vpn: vpn, ppn: ppn};
	endtask

	task automatic set_xlat(input logic en);
		wb_write(ADR_CTRL, {31'd0, en});
		xlat_on = en;
	endtask

	// Expected values are taken before the lookup so later loads cannot leak in
	task automatic lookup_check(input string name, input logic [31:0] vadr);
		xres_t       e;
		xres_t       a;
		logic [31:0] rd;
		e = ref_xlat(vadr, xlat_on);
		wb_write(ADR_VADR, vadr);
		wb_read(ADR_VADR, rd);
		a.padr = rd;
		wb_read(ADR_STAT, rd);
		a.padrv = rd[0];
		a.found = rd[1];
		name_q.push_back(name);
		exp_q.push_back(e);
		act_q.push_back(a);
	endtask

	// ==================================================
	// Compare process
	// ==================================================

	task automatic report_fail(input string name, input string what,
			input logic [31:0] exp, input logic [31:0] act);
		$display("[FAIL] %s %s expected 0x%08h actual 0x%08h", name, what, exp, act);
		$display("test failed");
		$fatal(1, "Mismatch in %s", name);
	endtask

	initial begin : compare
		xres_t e;
		xres_t a;
		string n;
		forever begin
			@(posedge clk);
			while (act_q.size() > 0) begin
				e = exp_q.pop_front();
				a = act_q.pop_front();
				n = name_q.pop_front();
				assert (a.padrv === e.padrv)
					else report_fail(n, "padrv", {31'd0, e.padrv}, {31'd0, a.padrv});
				assert (a.found === e.found)
					else report_fail(n, "found", {31'd0, e.found}, {31'd0, a.found});
				// On a miss the physical address carries no meaning
				if (e.padrv) begin
					assert (a.padr === e.padr)
						else report_fail(n, "padr", e.padr, a.padr);
				end
			end
		end
	end

	// ==================================================
	// Stimulus
	// ==================================================

	initial begin : stimulus
		logic [31:0]             r;
		logic [31:0]             d;
		logic [`HT_VPN_BITS-1:0] v;
		rst      = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		xlat_on  = 1'b0;
		for (int g = 0; g < `HT_GROUPS; g++)
			for (int s = 0; s < `HT_SLOTS; s++)
				shadow[g][s] = '0;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		// The table clears one group per cycle after reset
		repeat (20) @(negedge clk);

		// Translation off passes every address through
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			lookup_check("xlat_off", r);
		end

		// One entry per group for the first twelve groups
		// The two top page number bits stay clear
		for (int i = 0; i < 12; i++) begin
			r = $random(seed);
			v = {2'b00, r[11:4], r[3:0]};
			v[3:0] = 4'(i) ^ v[7:4] ^ v[11:8];
			pool[i] = v;
			load_entry(r[14:12], 1'b1, v, r[27:14]);
		end
		set_xlat(1'b1);
		for (int i = 0; i < 12; i++) begin
			r = $random(seed);
			lookup_check("xlat_hit", {pool[i], r[17:0]});
		end

		// Bit 12 is outside the hash, so same group but no tag matches
		r = $random(seed);
		lookup_check("miss", {pool[0] ^ 14'h1000, r[17:0]});

		// Lower slot invalid, higher slot valid, then both invalid
		v = pool[1] | 14'h2000;
		load_entry(3'd1, 1'b0, v, 14'h0aaa);
		load_entry(3'd6, 1'b1, v, 14'h1555);
		lookup_check("slot_priority", {v, 18'h2a5a5});
		load_entry(3'd6, 1'b0, v, 14'h1555);
		lookup_check("invalid_miss", {v, 18'h15a5a});

		// Mostly known page numbers so that hits stay common
		for (int i = 0; i < 150; i++) begin
			r = $random(seed);
			d = $random(seed);
			v = r[4] ? pool[r[3:0] % 12] : d[31:18];
			case (r[6:5])
				2'd0: load_entry(r[9:7], r[10] | r[11], v, d[13:0]);
				2'd1: set_xlat(r[12]);
				default: lookup_check("random_mix", {v, d[17:0]});
			endcase
		end

		// Give the compare process time to drain
		repeat (3) @(negedge clk);
		if (act_q.size() == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("test failed");
			$fatal(1, "Lookups were left unchecked at the end of the run");
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("test failed");
		$fatal(1, "Run did not finish within %0d ns", WATCHDOG_NS);
	end

endmodule

// ==== compile.f ====
+incdir+design
design/hash_table_pkg.sv
design/ht_wb_port.sv
design/ht_ptg_ram.sv
design/ht_search.sv
design/ht_padr.sv
design/ht_xlat_top.sv
sim/ht_xlat_chk.sv
sim/ht_xlat_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f compile.f --top-module ht_xlat_tb -Mdir obj_dir
	./obj_dir/Vht_xlat_tb

clean:
	rm -rf obj_dir
